/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = cpuCore_tb
FILELIST = cpuPipe.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* cpuPipe.f */
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeControl.sv
verilog/regFile.sv
verilog/alu.sv
verilog/stageReg.sv
verilog/cpuCore.sv
verification/cpuCore_props.sv
verification/cpuCore_tb.sv

/* verification/cpuCore_props.sv */
`timescale 1ns/1ps

module cpuCore_props (
    input logic            clk,
    input logic            arstN,
    input logic            flush,
    input logic            exValid,
    input logic            memRegWrite,
    input logic            wbRegWrite,
    input logic            halted,
    input pipePkg::fwdSelT fwdA,
    input pipePkg::fwdSelT fwdB
);

    // neither squashed instruction reaches execute
    flushEmptiesExecute: assert property (@(posedge clk) disable iff (!arstN)
        ($past(flush) || $past(flush, 2)) |-> !exValid)
        else $error("flushed instruction entered execute");

    fwdFromWritingStage: assert property (@(posedge clk) disable iff (!arstN)
        (fwdA != pipePkg::fwdMem || memRegWrite) && (fwdA != pipePkg::fwdWb || wbRegWrite) &&
        (fwdB != pipePkg::fwdMem || memRegWrite) && (fwdB != pipePkg::fwdWb || wbRegWrite))
        else $error("forwarding selected a stage that does not write a register");

    haltIsSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
        else $error("halted fell without a reset");

endmodule

bind pipeControl cpuCore_props u_cpuCoreProps (
    .clk(clk), .arstN(arstN), .flush(flush), .exValid(exValid),
    .memRegWrite(memRegWrite), .wbRegWrite(wbRegWrite), .halted(halted),
    .fwdA(fwdA), .fwdB(fwdB)
);

/* verification/cpuCore_tb.sv */
`timescale 1ns/1ps

module cpuCore_tb;

    localparam int progLen = 28;
    localparam int maxWait = 2000;
    localparam logic [1:0] reg0 = 2'd0;
    localparam logic [1:0] reg1 = 2'd1;
    localparam logic [1:0] reg2 = 2'd2;
    localparam logic [1:0] reg3 = 2'd3;

    // one program row with its expected WWD value and wrong-path mark
    typedef struct packed {
        logic [15:0] word;
        logic        hasWwd;
        logic [15:0] wwd;
        logic        offPath;
    } rowT;

    logic        clk;
    logic        arstN;
    logic [15:0] instrAddr, instrData;
    logic        dataRead, dataWrite;
    logic [15:0] dataAddr, dataWriteData, dataReadData;
    logic        outputValid;
    logic [15:0] outputPort, numInst;
    logic        halted;

    logic [15:0] instrMem [64];
    logic [15:0] dataMem [256];
    rowT         prog [progLen];
    logic [15:0] expWwd[$];
    logic [15:0] gotWwd[$];
    logic [15:0] storeWord, storeAddr, haltInst;
    int          seed;
    int          errorCount;
    int          lateOutputs;
    int          retireExp;
    bit          timedOut;

    cpuCore u_cpuCore (
        .clk, .arstN, .instrAddr, .instrData, .dataRead, .dataWrite, .dataAddr,
        .dataWriteData, .dataReadData, .outputValid, .outputPort, .numInst, .halted
    );

    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign instrData    = instrMem[instrAddr[5:0]];
    assign dataReadData = dataRead ? dataMem[dataAddr[7:0]] : 16'h0;

    always @(posedge clk) begin
        if (dataWrite) dataMem[dataAddr[7:0]] <= dataWriteData;
    end

    always @(negedge clk) begin
        if (arstN && outputValid) begin
            if (halted) begin
                $display("outputValid was seen at %0t after the core halted", $time);
                lateOutputs++;
            end
            gotWwd.push_back(outputPort);
        end
    end

    function automatic logic [15:0] rWord(input logic [1:0] rs, input logic [1:0] rt,
                                          input logic [1:0] rd, input logic [5:0] fn);
        return {isaPkg::opRtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] iWord(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] jWord(input logic [11:0] target);
        return {isaPkg::opJmp, target};
    endfunction

    function automatic logic [15:0] sext(input logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    function automatic rowT plainRow(input logic [15:0] word);
        return '{word: word, hasWwd: 1'b0, wwd: 16'h0, offPath: 1'b0};
    endfunction

    function automatic rowT wwdRow(input logic [15:0] word, input logic [15:0] value);
        return '{word: word, hasWwd: 1'b1, wwd: value, offPath: 1'b0};
    endfunction

    function automatic rowT wrongPathRow(input logic [15:0] word);
        return '{word: word, hasWwd: 1'b0, wwd: 16'h0, offPath: 1'b1};
    endfunction

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("Error at %0t ns: %s expected 0x%h, got 0x%h", $time, name, expected,
                     actual);
        end
    endtask

    // v0..v3 track the registers along the correct path
    task automatic buildProgram();
        logic [31:0] rnd;
        logic [7:0]  imm1, imm2, imm3;
        logic [15:0] v0, v1, v2, v3;
        rnd  = $random(seed);
        imm1 = rnd[7:0];
        rnd  = $random(seed);
        imm2 = rnd[7:0];
        rnd  = $random(seed);
        imm3 = rnd[7:0];
        v0 = 16'h0;
        v1 = v0 + sext(imm1);
        prog[0] = plainRow(iWord(isaPkg::opAdi, reg0, reg1, imm1));
        v2 = v1 + sext(imm2);
        prog[1] = plainRow(iWord(isaPkg::opAdi, reg1, reg2, imm2)); // from EX/MEM
        v3 = v1 + v2;
        prog[2] = plainRow(rWord(reg1, reg2, reg3, isaPkg::fnAdd));
        prog[3] = wwdRow(rWord(reg3, reg0, reg0, isaPkg::fnWwd), v3);
        v1 = v3 - v2;
        prog[4] = plainRow(rWord(reg3, reg2, reg1, isaPkg::fnSub));
        v2 = v2 + sext(imm3);
        prog[5] = plainRow(iWord(isaPkg::opAdi, reg2, reg2, imm3));
        v3 = v1 & v2;
        prog[6] = plainRow(rWord(reg1, reg2, reg3, isaPkg::fnAnd));
        v3 = v3 | v1;
        prog[7] = plainRow(rWord(reg3, reg1, reg3, isaPkg::fnOrr)); // reg1 via write-through
        prog[8] = wwdRow(rWord(reg3, reg0, reg0, isaPkg::fnWwd), v3);
        prog[9] = wwdRow(rWord(reg2, reg0, reg0, isaPkg::fnWwd), v2);
        v1 = v0 + 16'h0020;
        prog[10] = plainRow(iWord(isaPkg::opAdi, reg0, reg1, 8'h20));
        storeWord = v3;
        storeAddr = v1 + 16'h0002;
        prog[11] = plainRow(iWord(isaPkg::opSwd, reg1, reg3, 8'h02));
        v2 = storeWord;
        prog[12] = plainRow(iWord(isaPkg::opLwd, reg1, reg2, 8'h02));
        v0 = v2 + v1;
        prog[13] = plainRow(rWord(reg2, reg1, reg0, isaPkg::fnAdd)); // load-use stall
        prog[14] = wwdRow(rWord(reg0, reg0, reg0, isaPkg::fnWwd), v0);
        v3 = 16'hc300;
        prog[15] = plainRow(iWord(isaPkg::opLhi, reg0, reg3, 8'hc3));
        prog[16] = wwdRow(rWord(reg3, reg0, reg0, isaPkg::fnWwd), v3);
        prog[17] = plainRow(iWord(isaPkg::opBeq, reg3, reg3, 8'h02)); // taken to 20
        prog[18] = wrongPathRow(rWord(reg3, reg0, reg0, isaPkg::fnWwd));
        prog[19] = wrongPathRow(iWord(isaPkg::opAdi, reg1, reg1, 8'h01));
        prog[20] = plainRow(iWord(isaPkg::opBne, reg1, reg1, 8'h02)); // falls through
        prog[21] = wwdRow(rWord(reg1, reg0, reg0, isaPkg::fnWwd), v1);
        prog[22] = plainRow(jWord(12'd25));
        prog[23] = wrongPathRow(iWord(isaPkg::opAdi, reg1, reg1, 8'h01));
        prog[24] = wrongPathRow(rWord(reg3, reg0, reg0, isaPkg::fnWwd));
        prog[25] = wwdRow(rWord(reg1, reg0, reg0, isaPkg::fnWwd), v1);
        prog[26] = plainRow(rWord(reg0, reg0, reg0, isaPkg::fnHlt));
        prog[27] = plainRow(rWord(reg0, reg0, reg0, isaPkg::fnWwd)); // behind HLT
    endtask

    task automatic loadMemories();
        logic [7:0] fill;
        for (int i = 0; i < 64; i++) instrMem[i[5:0]] = 16'h0;
        for (int i = 0; i < progLen; i++) instrMem[i[5:0]] = prog[i[4:0]].word;
        for (int a = 0; a < 256; a++) begin
            fill = a[7:0];
            dataMem[a[7:0]] = {~fill, fill};
        end
    endtask

    // correct-path rows up to and including the first HLT retire
    task automatic buildExpected();
        bit seenHlt;
        seenHlt   = 1'b0;
        retireExp = 0;
        for (int i = 0; i < progLen; i++) begin
            if (!seenHlt && !prog[i[4:0]].offPath) begin
                retireExp++;
                if (prog[i[4:0]].hasWwd) expWwd.push_back(prog[i[4:0]].wwd);
                if (prog[i[4:0]].word[15:12] == isaPkg::opRtype &&
                    prog[i[4:0]].word[5:0] == isaPkg::fnHlt) seenHlt = 1'b1;
            end
        end
    endtask

    task automatic waitForWwd(input int idx);
        int n;
        n = 0;
        while (gotWwd.size() <= idx && n < maxWait) begin
            @(posedge clk);
            n++;
        end
        if (gotWwd.size() <= idx) begin
            $display("Timeout: WWD result %0d did not arrive within %0d cycles", idx, maxWait);
            timedOut = 1'b1;
        end
    endtask

    task automatic waitForHalt();
        int n;
        n = 0;
        while (!halted && n < maxWait) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", maxWait);
            timedOut = 1'b1;
        end
    endtask

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        seed        = 32'hae90_72fd;
        errorCount  = 0;
        lateOutputs = 0;
        timedOut    = 1'b0;
        buildProgram();
        loadMemories();
        buildExpected();

        repeat (16) @(posedge clk);
        #1;
        checkValue("dataRead", 16'h0, 16'(dataRead));
        checkValue("dataWrite", 16'h0, 16'(dataWrite));
        checkValue("outputValid", 16'h0, 16'(outputValid));
        checkValue("halted", 16'h0, 16'(halted));
        checkValue("numInst", 16'h0, numInst);
        #1 arstN = 1'b1;

        for (int k = 0; k < expWwd.size() && !timedOut; k++) begin
            waitForWwd(k);
            if (!timedOut) checkValue("outputPort", expWwd[k], gotWwd[k]);
        end
        if (!timedOut) waitForHalt();
        if (!timedOut) begin
            haltInst = numInst;
            repeat (20) @(negedge clk); // nothing may follow HLT
            checkValue("halted", 16'h1, 16'(halted));
            checkValue("numInst", 16'(retireExp), haltInst);
            checkValue("numInst after halt", 16'(retireExp), numInst);
            checkValue("WWD count", 16'(expWwd.size()), 16'(gotWwd.size()));
            checkValue("dataMem[storeAddr]", storeWord, dataMem[storeAddr[7:0]]);
        end
        errorCount += lateOutputs;

        $display("checks finished with %0d errors and %0d timeouts", errorCount,
                 timedOut ? 1 : 0);
        if (errorCount == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [isaPkg::wordW-1:0] a,
    input  logic [isaPkg::wordW-1:0] b,
    input  pipePkg::aluOpT           aluOp,
    output logic [isaPkg::wordW-1:0] result,
    output logic                     zero
);

    localparam int halfW = isaPkg::wordW / 2;

    always_comb begin
        case (aluOp)
            pipePkg::aluAdd:   result = a + b;
            pipePkg::aluSub:   result = a - b;
            pipePkg::aluAnd:   result = a & b;
            pipePkg::aluOr:    result = a | b;
            pipePkg::aluLhi:   result = {b[halfW-1:0], {halfW{1'b0}}}; // imm to upper byte
            pipePkg::aluPassA: result = a;
            pipePkg::aluCmpEq: result = a ^ b; // zero when equal
            default:           result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* verilog/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic                     clk,
    input  logic                     arstN,
    output logic [isaPkg::wordW-1:0] instrAddr,
    input  logic [isaPkg::wordW-1:0] instrData,
    output logic                     dataRead,
    output logic                     dataWrite,
    output logic [isaPkg::wordW-1:0] dataAddr,
    output logic [isaPkg::wordW-1:0] dataWriteData,
    input  logic [isaPkg::wordW-1:0] dataReadData,
    output logic                     outputValid,
    output logic [isaPkg::wordW-1:0] outputPort,
    output logic [isaPkg::wordW-1:0] numInst,
    output logic                     halted
);

    localparam int W = isaPkg::wordW;

    pipePkg::ifIdT  ifIdD, ifIdQ;
    pipePkg::idExT  idExD, idExQ;
    pipePkg::exMemT exMemD, exMemQ;
    pipePkg::memWbT memWbD, memWbQ;

    logic [W-1:0] pc, pcNext, branchTarget;
    logic [W-1:0] rfA, rfB, decImm;
    logic [W-1:0] opA, opB, aluB, aluResult;
    logic [isaPkg::regIdxW-1:0] decRs, decRt, ctlRd;
    logic pcWrite, ifIdWrite, bubble, flush, branchTaken, aluZero;
    logic ctlAluSrcImm, ctlMemRead, ctlMemWrite, ctlRegWrite;
    logic ctlWwd, ctlHlt, ctlBeq, ctlBne, ctlJmp;
    pipePkg::aluOpT  ctlAluOp;
    pipePkg::fwdSelT fwdA, fwdB;

    // fetch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcWrite) begin
            pc <= pcNext;
        end
    end

    assign pcNext = !branchTaken ? pc + W'(1) :
                    idExQ.isJmp  ? idExQ.jmpTarget : branchTarget;
    assign instrAddr = pc;
    assign ifIdD     = '{valid: 1'b1, pc: pc, instr: instrData};

    stageReg #(.payloadT(pipePkg::ifIdT)) u_ifId (
        .clk, .arstN, .hold(!ifIdWrite), .clear(flush), .d(ifIdD), .q(ifIdQ)
    );

    // decode
    assign decRs  = ifIdQ.instr[isaPkg::rsHi:isaPkg::rsLo];
    assign decRt  = ifIdQ.instr[isaPkg::rtHi:isaPkg::rtLo];
    assign decImm = {{(W - isaPkg::immHi - 1){ifIdQ.instr[isaPkg::immHi]}},
                     ifIdQ.instr[isaPkg::immHi:isaPkg::immLo]};

    pipeControl u_pipeControl (
        .clk, .arstN,
        .instr(ifIdQ.instr),
        .exRd(idExQ.rd), .exMemRead(idExQ.memRead), .exValid(idExQ.valid),
        .memRd(exMemQ.rd), .memRegWrite(exMemQ.regWrite),
        .wbRd(memWbQ.rd), .wbRegWrite(memWbQ.regWrite),
        .decRs, .decRt, .exRs(idExQ.rs), .exRt(idExQ.rt),
        .branchTaken, .halted,
        .pcWrite, .ifIdWrite, .bubble, .flush, .fwdA, .fwdB,
        .aluOp(ctlAluOp), .aluSrcImm(ctlAluSrcImm), .memRead(ctlMemRead),
        .memWrite(ctlMemWrite), .regWrite(ctlRegWrite), .rdSel(ctlRd),
        .isWwd(ctlWwd), .isHlt(ctlHlt), .isBeq(ctlBeq), .isBne(ctlBne), .isJmp(ctlJmp)
    );

    regFile u_regFile (
        .clk, .arstN, .rdAddrA(decRs), .rdAddrB(decRt),
        .wrAddr(memWbQ.rd), .wrData(memWbQ.writeValue),
        .wrEn(memWbQ.valid && memWbQ.regWrite),
        .rdDataA(rfA), .rdDataB(rfB)
    );

    always_comb begin
        idExD           = '0;
        idExD.valid     = ifIdQ.valid;
        idExD.pc        = ifIdQ.pc;
        idExD.opA       = rfA;
        idExD.opB       = rfB;
        idExD.imm       = decImm;
        idExD.rs        = decRs;
        idExD.rt        = decRt;
        idExD.rd        = ctlRd;
        idExD.aluOp     = ctlAluOp;
        idExD.aluSrcImm = ctlAluSrcImm;
        idExD.memRead   = ctlMemRead;
        idExD.memWrite  = ctlMemWrite;
        idExD.regWrite  = ctlRegWrite;
        idExD.isWwd     = ctlWwd;
        idExD.isHlt     = ctlHlt;
        idExD.isBeq     = ctlBeq;
        idExD.isBne     = ctlBne;
        idExD.isJmp     = ctlJmp;
        idExD.jmpTarget = {ifIdQ.pc[W-1:isaPkg::jmpHi+1], ifIdQ.instr[isaPkg::jmpHi:0]};
    end

    stageReg #(.payloadT(pipePkg::idExT)) u_idEx (
        .clk, .arstN, .hold(halted), .clear(bubble || flush || !ifIdQ.valid),
        .d(idExD), .q(idExQ)
    );

    // execute with forwarding
    always_comb begin
        case (fwdA)
            pipePkg::fwdMem: opA = exMemQ.aluResult;
            pipePkg::fwdWb:  opA = memWbQ.writeValue;
            default:         opA = idExQ.opA;
        endcase
        case (fwdB)
            pipePkg::fwdMem: opB = exMemQ.aluResult;
            pipePkg::fwdWb:  opB = memWbQ.writeValue;
            default:         opB = idExQ.opB;
        endcase
    end

    assign aluB = idExQ.aluSrcImm ? idExQ.imm : opB;

    alu u_alu (.a(opA), .b(aluB), .aluOp(idExQ.aluOp), .result(aluResult), .zero(aluZero));

    assign branchTarget = idExQ.pc + W'(1) + idExQ.imm;
    assign branchTaken  = idExQ.valid && (idExQ.isJmp || (idExQ.isBeq && aluZero) ||
                                          (idExQ.isBne && !aluZero));

    assign exMemD = '{valid: idExQ.valid, aluResult: aluResult, storeData: opB,
                      rd: idExQ.rd, memRead: idExQ.memRead, memWrite: idExQ.memWrite,
                      regWrite: idExQ.regWrite, isWwd: idExQ.isWwd, isHlt: idExQ.isHlt};

    stageReg #(.payloadT(pipePkg::exMemT)) u_exMem (
        .clk, .arstN, .hold(halted), .clear(1'b0), .d(exMemD), .q(exMemQ)
    );

    // memory answers in the same cycle
    assign dataRead      = exMemQ.valid && exMemQ.memRead;
    assign dataWrite     = exMemQ.valid && exMemQ.memWrite;
    assign dataAddr      = exMemQ.aluResult;
    assign dataWriteData = exMemQ.storeData;

    assign memWbD = '{valid: exMemQ.valid,
                      writeValue: exMemQ.memRead ? dataReadData : exMemQ.aluResult,
                      rd: exMemQ.rd, regWrite: exMemQ.regWrite, isWwd: exMemQ.isWwd,
                      wwdValue: exMemQ.aluResult, isHlt: exMemQ.isHlt};

    stageReg #(.payloadT(pipePkg::memWbT)) u_memWb (
        .clk, .arstN, .hold(halted), .clear(1'b0), .d(memWbD), .q(memWbQ)
    );

    // retirement one cycle after writeback
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outputValid <= 1'b0;
            numInst     <= '0;
            halted      <= 1'b0;
        end else begin
            outputValid <= !halted && memWbQ.valid && memWbQ.isWwd;
            if (!halted && memWbQ.valid) begin
                numInst <= numInst + W'(1);
                if (memWbQ.isHlt) halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memWbQ.valid && memWbQ.isWwd) outputPort <= memWbQ.wwdValue;
    end

endmodule

/* verilog/isaPkg.sv */
package isaPkg;

    localparam int wordW    = 16;
    localparam int regCount = 4;
    localparam int regIdxW  = 2;

    // opcodes in instr[15:12]
    localparam logic [3:0] opBne   = 4'd0;
    localparam logic [3:0] opBeq   = 4'd1;
    localparam logic [3:0] opAdi   = 4'd4;
    localparam logic [3:0] opLhi   = 4'd6;
    localparam logic [3:0] opLwd   = 4'd7;
    localparam logic [3:0] opSwd   = 4'd8;
    localparam logic [3:0] opJmp   = 4'd9;
    localparam logic [3:0] opRtype = 4'd15;

    // R-type function codes in instr[5:0]
    localparam logic [5:0] fnAdd = 6'd0;
    localparam logic [5:0] fnSub = 6'd1;
    localparam logic [5:0] fnAnd = 6'd2;
    localparam logic [5:0] fnOrr = 6'd3;
    localparam logic [5:0] fnWwd = 6'd28;
    localparam logic [5:0] fnHlt = 6'd29;

    // field positions
    localparam int opHi  = 15;
    localparam int opLo  = 12;
    localparam int rsHi  = 11;
    localparam int rsLo  = 10;
    localparam int rtHi  = 9;
    localparam int rtLo  = 8;
    localparam int rdHi  = 7;
    localparam int rdLo  = 6;
    localparam int fnHi  = 5;
    localparam int fnLo  = 0;
    localparam int immHi = 7;
    localparam int immLo = 0;
    localparam int jmpHi = 11;

endpackage

/* verilog/pipeControl.sv */
`timescale 1ns/1ps

module pipeControl (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [isaPkg::wordW-1:0]   instr,
    input  logic [isaPkg::regIdxW-1:0] exRd,
    input  logic                       exMemRead,
    input  logic                       exValid,
    input  logic [isaPkg::regIdxW-1:0] memRd,
    input  logic                       memRegWrite,
    input  logic [isaPkg::regIdxW-1:0] wbRd,
    input  logic                       wbRegWrite,
    input  logic [isaPkg::regIdxW-1:0] decRs,
    input  logic [isaPkg::regIdxW-1:0] decRt,
    input  logic [isaPkg::regIdxW-1:0] exRs,
    input  logic [isaPkg::regIdxW-1:0] exRt,
    input  logic                       branchTaken,
    input  logic                       halted,
    output logic                       pcWrite,
    output logic                       ifIdWrite,
    output logic                       bubble,
    output logic                       flush,
    output pipePkg::fwdSelT            fwdA,
    output pipePkg::fwdSelT            fwdB,
    output pipePkg::aluOpT             aluOp,
    output logic                       aluSrcImm,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       regWrite,
    output logic [isaPkg::regIdxW-1:0] rdSel,
    output logic                       isWwd,
    output logic                       isHlt,
    output logic                       isBeq,
    output logic                       isBne,
    output logic                       isJmp
);

    logic [3:0] opcode;
    logic [5:0] fn;
    logic       loadUse;
    logic       haltLatch;
    logic       freeze;

    function automatic pipePkg::fwdSelT pickFwd(input logic [isaPkg::regIdxW-1:0] src);
        if (memRegWrite && memRd == src) return pipePkg::fwdMem; // newer stage wins
        if (wbRegWrite && wbRd == src) return pipePkg::fwdWb;
        return pipePkg::fwdNone;
    endfunction

    assign opcode = instr[isaPkg::opHi:isaPkg::opLo];
    assign fn     = instr[isaPkg::fnHi:isaPkg::fnLo];

    always_comb begin
        aluOp     = pipePkg::aluAdd;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        rdSel     = instr[isaPkg::rtHi:isaPkg::rtLo]; // I-type writes rt
        isWwd     = 1'b0;
        isHlt     = 1'b0;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJmp     = 1'b0;
        case (opcode)
            isaPkg::opRtype: begin
                rdSel = instr[isaPkg::rdHi:isaPkg::rdLo];
                case (fn)
                    isaPkg::fnAdd: regWrite = 1'b1;
                    isaPkg::fnSub: begin
                        aluOp    = pipePkg::aluSub;
                        regWrite = 1'b1;
                    end
                    isaPkg::fnAnd: begin
                        aluOp    = pipePkg::aluAnd;
                        regWrite = 1'b1;
                    end
                    isaPkg::fnOrr: begin
                        aluOp    = pipePkg::aluOr;
                        regWrite = 1'b1;
                    end
                    isaPkg::fnWwd: begin
                        aluOp = pipePkg::aluPassA;
                        isWwd = 1'b1;
                    end
                    isaPkg::fnHlt: isHlt = 1'b1;
                    default: ;
                endcase
            end
            isaPkg::opAdi: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opLhi: begin
                aluOp     = pipePkg::aluLhi;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opLwd: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opSwd: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            isaPkg::opBeq: begin
                aluOp = pipePkg::aluCmpEq;
                isBeq = 1'b1;
            end
            isaPkg::opBne: begin
                aluOp = pipePkg::aluCmpEq;
                isBne = 1'b1;
            end
            isaPkg::opJmp: isJmp = 1'b1;
            default: ;
        endcase
    end

    // load in execute feeding the instruction in decode
    assign loadUse = exValid && exMemRead && (exRd == decRs || exRd == decRt);

    // HLT entering execute stops fetch and everything behind it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltLatch <= 1'b0;
        end else if (isHlt && !loadUse && !flush) begin
            haltLatch <= 1'b1;
        end
    end

    assign freeze    = haltLatch || halted;
    assign flush     = branchTaken;
    assign pcWrite   = !freeze && (!loadUse || flush);
    assign ifIdWrite = !freeze && !loadUse;
    assign bubble    = loadUse || freeze;

    always_comb begin
        fwdA = pickFwd(exRs);
        fwdB = pickFwd(exRt);
    end

endmodule

/* verilog/pipePkg.sv */
package pipePkg;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluLhi, aluPassA, aluCmpEq
    } aluOpT;

    // source of an execute operand
    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

    typedef struct packed {
        logic                      valid;
        logic [isaPkg::wordW-1:0]  pc;
        logic [isaPkg::wordW-1:0]  instr;
    } ifIdT;

    typedef struct packed {
        logic                       valid;
        logic [isaPkg::wordW-1:0]   pc;
        logic [isaPkg::wordW-1:0]   opA;
        logic [isaPkg::wordW-1:0]   opB;
        logic [isaPkg::wordW-1:0]   imm;
        logic [isaPkg::regIdxW-1:0] rs;
        logic [isaPkg::regIdxW-1:0] rt;
        logic [isaPkg::regIdxW-1:0] rd;
        aluOpT                      aluOp;
        logic                       aluSrcImm;
        logic                       memRead;
        logic                       memWrite;
        logic                       regWrite;
        logic                       isWwd;
        logic                       isHlt;
        logic                       isBeq;
        logic                       isBne;
        logic                       isJmp;
        logic [isaPkg::wordW-1:0]   jmpTarget;
    } idExT;

    typedef struct packed {
        logic                       valid;
        logic [isaPkg::wordW-1:0]   aluResult;
        logic [isaPkg::wordW-1:0]   storeData;
        logic [isaPkg::regIdxW-1:0] rd;
        logic                       memRead;
        logic                       memWrite;
        logic                       regWrite;
        logic                       isWwd;
        logic                       isHlt;
    } exMemT;

    typedef struct packed {
        logic                       valid;
        logic [isaPkg::wordW-1:0]   writeValue;
        logic [isaPkg::regIdxW-1:0] rd;
        logic                       regWrite;
        logic                       isWwd;
        logic [isaPkg::wordW-1:0]   wwdValue;
        logic                       isHlt;
    } memWbT;

endpackage

/* verilog/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [isaPkg::regIdxW-1:0] rdAddrA,
    input  logic [isaPkg::regIdxW-1:0] rdAddrB,
    input  logic [isaPkg::regIdxW-1:0] wrAddr,
    input  logic [isaPkg::wordW-1:0]   wrData,
    input  logic                       wrEn,
    output logic [isaPkg::wordW-1:0]   rdDataA,
    output logic [isaPkg::wordW-1:0]   rdDataB
);

    logic [isaPkg::wordW-1:0] regs [isaPkg::regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so decode sees the writeback value
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

/* verilog/stageReg.sv */
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    clear,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (clear) begin
            q <= '0; // valid drops with the rest
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule
